// ==== flist.f ====
+incdir+include
rtl/dp_pkg.sv
rtl/io_predication.sv
rtl/data_memory.sv
rtl/alu_writeback.sv
rtl/datapath.sv
verif/tb_datapath.sv

// ==== Makefile ====
# Verilator build and run of the datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_datapath
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

# Build, run and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_datapath.sv ====
// Table-driven testbench for the datapath: stimulus table, reference memory model and checks

`include "dp_macros.svh"

module tb_datapath;
    timeunit 1ns;
    timeprecision 1ps;

    import dp_pkg::*;

    localparam int NUM_TESTS = 19;
    localparam int TIMEOUT_CYCLES = 4 * NUM_TESTS + 20;
    localparam int PORTS = `DP_IO_PORT_COUNT;
    localparam int W = `DP_WORD_WIDTH;
    localparam logic [4*PORTS-1:0] ALL_EF = '1;
    localparam logic [`DP_ADDR_WIDTH-1:0] IO_P0 = 8'hFC;
    localparam logic [`DP_ADDR_WIDTH-1:0] IO_P1 = 8'hFD;
    localparam logic [`DP_ADDR_WIDTH-1:0] IO_P2 = 8'hFE;
    localparam logic [`DP_ADDR_WIDTH-1:0] IO_P3 = 8'hFF;

    typedef struct packed {
        instr_t           instr;
        logic             cancel;
        logic [4*PORTS-1:0] ef;     // {read A, read B, write A, write B}, one bit per port
        word_t            io_a;     // word on the addressed A read port
        word_t            io_b;
        logic             exp_ready;
        logic             exp_live;
        word_t            exp_result;
        logic             exp_carry;
        logic             exp_ovf;
        logic [PORTS-1:0] exp_wren_a;
        logic [PORTS-1:0] exp_wren_b;
    } test_entry_t;

    logic                 clock = 1'b0;
    logic                 rst;
    logic                 instr_valid;
    instr_t               instr;
    logic                 cancel;
    logic [PORTS-1:0]     io_read_ef_a;
    logic [PORTS-1:0]     io_read_ef_b;
    logic [PORTS-1:0]     io_write_ef_a;
    logic [PORTS-1:0]     io_write_ef_b;
    logic [PORTS*W-1:0]   io_read_data_a;
    logic [PORTS*W-1:0]   io_read_data_b;
    logic [PORTS-1:0]     io_rden_a;
    logic [PORTS-1:0]     io_rden_b;
    logic [PORTS-1:0]     io_wren_a;
    logic [PORTS-1:0]     io_wren_b;
    word_t                io_write_data_a;
    word_t                io_write_data_b;
    logic                 io_ready;
    word_t                result;
    logic                 result_valid;
    logic                 carry_out;
    logic                 overflow;

    test_entry_t tests [NUM_TESTS];
    word_t       ref_mem_a [2 ** `DP_ADDR_WIDTH];
    word_t       ref_mem_b [2 ** `DP_ADDR_WIDTH];
    int          num_loaded = 0;
    int          cycle_count = 0;
    int          test_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    datapath datapath_inst (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Helpers

    // Top six address bits all ones select an I/O port
    function automatic logic addr_is_io(input logic [`DP_ADDR_WIDTH-1:0] addr);
        return addr[`DP_ADDR_WIDTH-1:`DP_IO_PORT_BITS] == `DP_IO_REGION;
    endfunction

    function automatic logic [PORTS-1:0] port_mask(input logic on,
                                                   input logic [`DP_ADDR_WIDTH-1:0] addr);
        logic [PORTS-1:0] mask;
        mask = '0;
        if (on) mask[addr[`DP_IO_PORT_BITS-1:0]] = 1'b1;
        return mask;
    endfunction

    // Random filler on every port, the chosen word on the addressed one
    function automatic logic [PORTS*W-1:0] port_data(input logic [`DP_ADDR_WIDTH-1:0] addr,
                                                     input word_t word);
        logic [PORTS*W-1:0] data;
        for (int p = 0; p < PORTS; p++) data[p*W +: W] = word_t'($urandom);
        if (addr_is_io(addr)) data[addr[`DP_IO_PORT_BITS-1:0]*W +: W] = word;
        return data;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic add_test(input alu_op_e op, input logic [7:0] ra, input logic [7:0] rb,
                            input logic [7:0] wa, input logic [7:0] wb, input logic cncl,
                            input logic [4*PORTS-1:0] ef, input word_t io_a, input word_t io_b,
                            input logic rdy, input logic live, input word_t res,
                            input logic c, input logic v,
                            input logic [PORTS-1:0] wren_a, input logic [PORTS-1:0] wren_b);
        test_entry_t e;
        e.instr.op = op;
        e.instr.read_a.index = ra;
        e.instr.read_b.index = rb;
        e.instr.write_a.index = wa;
        e.instr.write_b.index = wb;
        e.cancel = cncl;
        e.ef = ef;
        e.io_a = io_a;
        e.io_b = io_b;
        e.exp_ready = rdy;
        e.exp_live = live;
        e.exp_result = res;
        e.exp_carry = c;
        e.exp_ovf = v;
        e.exp_wren_a = wren_a;
        e.exp_wren_b = wren_b;
        tests[num_loaded] = e;
        num_loaded++;
    endtask

    // ------------------------------------------------------------------
    // Stimulus table

    task automatic load_table();
        // op, read A, read B, write A, write B, cancel, empty/full, I/O words,
        // ready, live, result, carry, overflow, wren A, wren B
        add_test(OP_PASS_A, IO_P0, 8'h00, 8'h00, 8'h40, 0, ALL_EF, 16'h7000, 16'h0000,
                 1, 1, 16'h7000, 0, 0, 4'h0, 4'h0);
        add_test(OP_PASS_B, 8'h41, IO_P1, 8'h41, 8'h00, 0, ALL_EF, 16'h0000, 16'h2000,
                 1, 1, 16'h2000, 0, 0, 4'h0, 4'h0);
        add_test(OP_PASS_A, IO_P2, 8'h01, 8'h01, 8'h42, 0, ALL_EF, 16'h1234, 16'h0000,
                 1, 1, 16'h1234, 0, 0, 4'h0, 4'h0);
        add_test(OP_PASS_B, 8'h43, IO_P3, 8'h43, 8'h01, 0, ALL_EF, 16'h0000, 16'h5678,
                 1, 1, 16'h5678, 0, 0, 4'h0, 4'h0);
        // Readback of the first I/O load
        add_test(OP_PASS_A, 8'h00, 8'h00, 8'h50, 8'h50, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'h7000, 0, 0, 4'h0, 4'h0);
        add_test(OP_ADD, 8'h00, 8'h00, 8'h51, 8'h51, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'h9000, 0, 1, 4'h0, 4'h0);
        add_test(OP_ADD, 8'h51, 8'h51, 8'h52, 8'h52, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'h2000, 1, 1, 4'h0, 4'h0);
        add_test(OP_SUB, 8'h01, 8'h01, 8'h53, 8'h53, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'hBBBC, 1, 0, 4'h0, 4'h0);
        add_test(OP_SUB, 8'h00, 8'h51, 8'h54, 8'h54, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'hE000, 1, 1, 4'h0, 4'h0);
        add_test(OP_AND, 8'h01, 8'h01, 8'h55, 8'h55, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'h1230, 0, 0, 4'h0, 4'h0);
        add_test(OP_OR, 8'h01, 8'h01, 8'h56, 8'h56, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'h567C, 0, 0, 4'h0, 4'h0);
        add_test(OP_XOR, 8'h01, 8'h01, 8'h57, 8'h57, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'h444C, 0, 0, 4'h0, 4'h0);
        add_test(OP_NOT_A, 8'h01, 8'h01, 8'h58, 8'h58, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'hEDCB, 0, 0, 4'h0, 4'h0);
        // Port 2 of read side A is empty
        add_test(OP_PASS_A, IO_P2, 8'h00, 8'h00, 8'h00, 0, 16'hBFFF, 16'hDEAD, 16'h0000,
                 0, 0, 16'h0000, 0, 0, 4'h0, 4'h0);
        add_test(OP_PASS_A, 8'h00, 8'h00, 8'h60, 8'h60, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'h7000, 0, 0, 4'h0, 4'h0);
        add_test(OP_PASS_A, 8'h01, 8'h01, IO_P1, IO_P2, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'h1234, 0, 0, 4'h2, 4'h4);
        // Port 3 of write side A is full
        add_test(OP_PASS_A, 8'h01, 8'h01, IO_P3, IO_P0, 0, 16'hFF7F, 16'h0000, 16'h0000,
                 0, 0, 16'h0000, 0, 0, 4'h0, 4'h0);
        add_test(OP_PASS_A, IO_P0, 8'h00, 8'h00, 8'h00, 1, ALL_EF, 16'hBEEF, 16'h0000,
                 1, 0, 16'h0000, 0, 0, 4'h0, 4'h0);
        add_test(OP_PASS_B, 8'h00, 8'h00, 8'h61, 8'h61, 0, ALL_EF, 16'h0000, 16'h0000,
                 1, 1, 16'h2000, 0, 0, 4'h0, 4'h0);
    endtask

    // ------------------------------------------------------------------
    // One instruction, strobe to writeback

    task automatic run_test(input int idx);
        test_entry_t e;
        alu_op_e     op;
        logic [7:0]  ra;
        logic [7:0]  rb;
        logic [7:0]  wa;
        logic [7:0]  wb;
        e = tests[idx];
        op = e.instr.op;
        ra = e.instr.read_a.index;
        rb = e.instr.read_b.index;
        wa = e.instr.write_a.index;
        wb = e.instr.write_b.index;
        test_errors = 0;

        // Cycle 0
        @(negedge clock);
        instr_valid = 1'b1;
        instr = e.instr;
        cancel = e.cancel;
        {io_read_ef_a, io_read_ef_b, io_write_ef_a, io_write_ef_b} = e.ef;
        io_read_data_a = port_data(ra, e.io_a);
        io_read_data_b = port_data(rb, e.io_b);
        @(posedge clock);
        check_value("io_rden_a", word_t'(io_rden_a),
                    word_t'(port_mask(e.exp_live && addr_is_io(ra), ra)));
        check_value("io_rden_b", word_t'(io_rden_b),
                    word_t'(port_mask(e.exp_live && addr_is_io(rb), rb)));

        // Cycle 1
        @(negedge clock);
        check_value("io_ready", word_t'(io_ready), word_t'(e.exp_ready));
        instr_valid = 1'b0;
        cancel = 1'b0;

        // Cycle 2
        @(negedge clock);
        check_value("result_valid", word_t'(result_valid), word_t'(e.exp_live));
        check_value("io_wren_a", word_t'(io_wren_a), word_t'(e.exp_wren_a));
        check_value("io_wren_b", word_t'(io_wren_b), word_t'(e.exp_wren_b));
        if (e.exp_live) begin
            check_value("result", result, e.exp_result);
            check_value("carry_out", word_t'(carry_out), word_t'(e.exp_carry));
            check_value("overflow", word_t'(overflow), word_t'(e.exp_ovf));
            if (op == OP_PASS_A && !addr_is_io(ra))
                check_value("result (memory model A)", result, ref_mem_a[ra]);
            if (op == OP_PASS_B && !addr_is_io(rb))
                check_value("result (memory model B)", result, ref_mem_b[rb]);
            if (e.exp_wren_a != '0) check_value("io_write_data_a", io_write_data_a, e.exp_result);
            if (e.exp_wren_b != '0) check_value("io_write_data_b", io_write_data_b, e.exp_result);
            if (!addr_is_io(wa)) ref_mem_a[wa] = e.exp_result;
            if (!addr_is_io(wb)) ref_mem_b[wb] = e.exp_result;
        end
        @(negedge clock);
        $display("test %0d %s: %s", idx, op.name(), (test_errors == 0) ? "passed" : "failed");
    endtask

    initial begin
        void'($urandom(14335));
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        cancel = 1'b0;
        io_read_ef_a = '0;
        io_read_ef_b = '0;
        io_write_ef_a = '0;
        io_write_ef_b = '0;
        io_read_data_a = '0;
        io_read_data_b = '0;
        load_table();
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
            if (test_errors == 0) pass_count++;
            else fail_count++;
        end

        $display("%0d tests: %0d passed, %0d failed", NUM_TESTS, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== rtl/datapath.sv ====
// Datapath top: I/O predication and data memory in parallel, then ALU and writeback

`include "dp_macros.svh"

module datapath (
    input  logic                                        clock,
    input  logic                                        rst,

    // Instruction strobe and cancel of the same instruction
    input  logic                                        instr_valid,
    input  dp_pkg::instr_t                              instr,
    input  logic                                        cancel,

    // I/O ports, empty/full bits are 1 when the port can go ahead
    input  logic [`DP_IO_PORT_COUNT-1:0]                io_read_ef_a,
    input  logic [`DP_IO_PORT_COUNT-1:0]                io_read_ef_b,
    input  logic [`DP_IO_PORT_COUNT-1:0]                io_write_ef_a,
    input  logic [`DP_IO_PORT_COUNT-1:0]                io_write_ef_b,
    input  logic [`DP_IO_PORT_COUNT*`DP_WORD_WIDTH-1:0] io_read_data_a,
    input  logic [`DP_IO_PORT_COUNT*`DP_WORD_WIDTH-1:0] io_read_data_b,
    output logic [`DP_IO_PORT_COUNT-1:0]                io_rden_a,
    output logic [`DP_IO_PORT_COUNT-1:0]                io_rden_b,
    output logic [`DP_IO_PORT_COUNT-1:0]                io_wren_a,
    output logic [`DP_IO_PORT_COUNT-1:0]                io_wren_b,
    output dp_pkg::word_t                               io_write_data_a,
    output dp_pkg::word_t                               io_write_data_b,

    // Predication and result
    output logic                                        io_ready,
    output dp_pkg::word_t                               result,
    output logic                                        result_valid,
    output logic                                        carry_out,
    output logic                                        overflow
);

    import dp_pkg::*;

    pred_t   pred;
    logic    pred_valid;
    mem_rd_t mem_rd;
    mem_wr_t mem_wr;

    // ------------------------------------------------------------------
    // Stage 1, predication and memory read side by side

    io_predication io_predication_inst (
        .clock          (clock),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .cancel         (cancel),
        .io_read_ef_a   (io_read_ef_a),
        .io_read_ef_b   (io_read_ef_b),
        .io_write_ef_a  (io_write_ef_a),
        .io_write_ef_b  (io_write_ef_b),
        .io_read_data_a (io_read_data_a),
        .io_read_data_b (io_read_data_b),
        .io_rden_a      (io_rden_a),
        .io_rden_b      (io_rden_b),
        .io_ready       (io_ready),
        .pred           (pred),
        .pred_valid     (pred_valid)
    );

    data_memory data_memory_inst (
        .clock       (clock),
        .read_addr_a (instr.read_a),
        .read_addr_b (instr.read_b),
        .rd          (mem_rd),
        .wr          (mem_wr)
    );

    // ------------------------------------------------------------------
    // Stage 2, combine and write back

    alu_writeback alu_writeback_inst (
        .clock           (clock),
        .rst             (rst),
        .pred            (pred),
        .pred_valid      (pred_valid),
        .rd              (mem_rd),
        .wr              (mem_wr),
        .result          (result),
        .result_valid    (result_valid),
        .carry_out       (carry_out),
        .overflow        (overflow),
        .io_write_data_a (io_write_data_a),
        .io_write_data_b (io_write_data_b),
        .io_wren_a       (io_wren_a),
        .io_wren_b       (io_wren_b)
    );

endmodule

// ==== rtl/alu_writeback.sv ====
// ALU and writeback: operand select, result with carry/overflow, memory and I/O writes

`include "dp_macros.svh"

module alu_writeback (
    input  logic                            clock,
    input  logic                            rst,
    input  dp_pkg::pred_t                   pred,
    input  logic                            pred_valid,
    input  dp_pkg::mem_rd_t                 rd,
    output dp_pkg::mem_wr_t                 wr,
    output dp_pkg::word_t                   result,
    output logic                            result_valid,
    output logic                            carry_out,
    output logic                            overflow,
    output dp_pkg::word_t                   io_write_data_a,
    output dp_pkg::word_t                   io_write_data_b,
    output logic [`DP_IO_PORT_COUNT-1:0]    io_wren_a,
    output logic [`DP_IO_PORT_COUNT-1:0]    io_wren_b
);

    import dp_pkg::*;

    localparam int MSB = `DP_WORD_WIDTH - 1;
    localparam logic [`DP_IO_PORT_COUNT-1:0] PORT_ONE = 1;

    word_t                   op_a;
    word_t                   op_b;
    word_t                   alu_res;
    logic                    alu_carry;
    logic                    alu_ovf;
    logic [`DP_WORD_WIDTH:0] wide;
    logic                    live;

    // ------------------------------------------------------------------
    // Operand select

    assign op_a = pred.rd_io_a ? pred.io_word_a : rd.a;
    assign op_b = pred.rd_io_b ? pred.io_word_b : rd.b;

    // ------------------------------------------------------------------
    // ALU

    always_comb begin
        wide      = '0;
        alu_res   = '0;
        alu_carry = 1'b0;
        alu_ovf   = 1'b0;
        unique case (pred.op)
            OP_PASS_A: alu_res = op_a;
            OP_PASS_B: alu_res = op_b;
            OP_ADD: begin
                wide      = {1'b0, op_a} + {1'b0, op_b};
                alu_res   = wide[MSB:0];
                alu_carry = wide[`DP_WORD_WIDTH];
                // Same signs in, different sign out
                alu_ovf   = (op_a[MSB] == op_b[MSB]) && (alu_res[MSB] != op_a[MSB]);
            end
            OP_SUB: begin
                // Top bit of the extended difference is the borrow
                wide      = {1'b0, op_a} - {1'b0, op_b};
                alu_res   = wide[MSB:0];
                alu_carry = wide[`DP_WORD_WIDTH];
                alu_ovf   = (op_a[MSB] != op_b[MSB]) && (alu_res[MSB] != op_a[MSB]);
            end
            OP_AND:   alu_res = op_a & op_b;
            OP_OR:    alu_res = op_a | op_b;
            OP_XOR:   alu_res = op_a ^ op_b;
            OP_NOT_A: alu_res = ~op_a;
        endcase
    end

    // ------------------------------------------------------------------
    // Output register and writeback

    // Annulled instructions still flow through, they just write nothing
    assign live = pred_valid && pred.live;

    always_ff @(posedge clock) begin
        result          <= alu_res;
        carry_out       <= alu_carry;
        overflow        <= alu_ovf;
        io_write_data_a <= alu_res;
        io_write_data_b <= alu_res;
        wr.addr_a       <= pred.write_a;
        wr.addr_b       <= pred.write_b;
        wr.data         <= alu_res;
        if (rst) begin
            result_valid <= 1'b0;
            wr.en_a      <= 1'b0;
            wr.en_b      <= 1'b0;
            io_wren_a    <= '0;
            io_wren_b    <= '0;
        end else begin
            result_valid <= live;
            wr.en_a      <= live && !pred.wr_io_a;
            wr.en_b      <= live && !pred.wr_io_b;
            io_wren_a    <= (live && pred.wr_io_a) ? (PORT_ONE << pred.write_a.io.port) : '0;
            io_wren_b    <= (live && pred.wr_io_b) ? (PORT_ONE << pred.write_b.io.port) : '0;
        end
    end

endmodule

// ==== rtl/data_memory.sv ====
// A and B data memories: registered reads, writeback writes

`include "dp_macros.svh"

module data_memory (
    input  logic            clock,
    input  dp_pkg::addr_u   read_addr_a,
    input  dp_pkg::addr_u   read_addr_b,
    output dp_pkg::mem_rd_t rd,
    input  dp_pkg::mem_wr_t wr
);

    import dp_pkg::*;

    localparam int DEPTH = 2 ** `DP_ADDR_WIDTH;

    word_t mem_a [DEPTH];
    word_t mem_b [DEPTH];

    // ------------------------------------------------------------------
    // Reads

    // One cycle latency, old data on a same-cycle write to the same word
    always_ff @(posedge clock) begin
        rd.a <= mem_a[read_addr_a.index];
        rd.b <= mem_b[read_addr_b.index];
    end

    // ------------------------------------------------------------------
    // Writes

    // Both sides take the same result word, each at its own address
    always_ff @(posedge clock) begin
        if (wr.en_a) begin
            mem_a[wr.addr_a.index] <= wr.data;
        end
        if (wr.en_b) begin
            mem_b[wr.addr_b.index] <= wr.data;
        end
    end

endmodule

// ==== rtl/io_predication.sv ====
// I/O predication: I/O operand decode, empty/full check, read enables, stage-1 register

`include "dp_macros.svh"

module io_predication (
    input  logic                                     clock,
    input  logic                                     rst,
    input  logic                                     instr_valid,
    input  dp_pkg::instr_t                           instr,
    input  logic                                     cancel,
    input  logic [`DP_IO_PORT_COUNT-1:0]             io_read_ef_a,
    input  logic [`DP_IO_PORT_COUNT-1:0]             io_read_ef_b,
    input  logic [`DP_IO_PORT_COUNT-1:0]             io_write_ef_a,
    input  logic [`DP_IO_PORT_COUNT-1:0]             io_write_ef_b,
    input  logic [`DP_IO_PORT_COUNT*`DP_WORD_WIDTH-1:0] io_read_data_a,
    input  logic [`DP_IO_PORT_COUNT*`DP_WORD_WIDTH-1:0] io_read_data_b,
    output logic [`DP_IO_PORT_COUNT-1:0]             io_rden_a,
    output logic [`DP_IO_PORT_COUNT-1:0]             io_rden_b,
    output logic                                     io_ready,
    output dp_pkg::pred_t                            pred,
    output logic                                     pred_valid
);

    import dp_pkg::*;

    localparam logic [`DP_IO_PORT_COUNT-1:0] PORT_ONE = 1;

    function automatic logic is_io(input addr_u addr);
        return addr.io.region == `DP_IO_REGION;
    endfunction

    // Word of the addressed port out of the flattened port data
    function automatic word_t port_word(
        input logic [`DP_IO_PORT_COUNT*`DP_WORD_WIDTH-1:0] data,
        input logic [`DP_IO_PORT_BITS-1:0]                 port
    );
        return data[port*`DP_WORD_WIDTH +: `DP_WORD_WIDTH];
    endfunction

    logic rd_io_a;
    logic rd_io_b;
    logic wr_io_a;
    logic wr_io_b;
    logic ready;
    logic live;

    // ------------------------------------------------------------------
    // Operand decode and predication

    assign rd_io_a = is_io(instr.read_a);
    assign rd_io_b = is_io(instr.read_b);
    assign wr_io_a = is_io(instr.write_a);
    assign wr_io_b = is_io(instr.write_b);

    // Every touched port must be able to go ahead, memory operands always can
    assign ready = (!rd_io_a || io_read_ef_a[instr.read_a.io.port])
                && (!rd_io_b || io_read_ef_b[instr.read_b.io.port])
                && (!wr_io_a || io_write_ef_a[instr.write_a.io.port])
                && (!wr_io_b || io_write_ef_b[instr.write_b.io.port]);

    assign live = instr_valid && ready && !cancel;

    // Pop the source ports only for an instruction that will execute
    assign io_rden_a = (live && rd_io_a) ? (PORT_ONE << instr.read_a.io.port) : '0;
    assign io_rden_b = (live && rd_io_b) ? (PORT_ONE << instr.read_b.io.port) : '0;

    // ------------------------------------------------------------------
    // Stage-1 register, runs in parallel with the memory read

    always_ff @(posedge clock) begin
        if (instr_valid) begin
            pred.live      <= live;
            pred.ready     <= ready;
            pred.rd_io_a   <= rd_io_a;
            pred.rd_io_b   <= rd_io_b;
            pred.io_word_a <= port_word(io_read_data_a, instr.read_a.io.port);
            pred.io_word_b <= port_word(io_read_data_b, instr.read_b.io.port);
            pred.wr_io_a   <= wr_io_a;
            pred.wr_io_b   <= wr_io_b;
            pred.write_a   <= instr.write_a;
            pred.write_b   <= instr.write_b;
            pred.op        <= instr.op;
        end
        if (rst) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= instr_valid;
        end
    end

    // Cancel does not affect this, only the port state does
    assign io_ready = pred_valid && pred.ready;

endmodule

// ==== rtl/dp_pkg.sv ====
// Datapath package: word, operand address union, ALU op, instruction and stage types

`include "dp_macros.svh"

package dp_pkg;

    // ------------------------------------------------------------------
    // Basic words and operand addresses

    typedef logic [`DP_WORD_WIDTH-1:0] word_t;

    // I/O view of an operand address
    typedef struct packed {
        logic [`DP_ADDR_WIDTH-`DP_IO_PORT_BITS-1:0] region;
        logic [`DP_IO_PORT_BITS-1:0]                port;
    } io_addr_t;

    // Same address bits read either as a memory index or as an I/O port select
    typedef union packed {
        logic [`DP_ADDR_WIDTH-1:0] index;
        io_addr_t                  io;
    } addr_u;

    typedef enum logic [`DP_OP_WIDTH-1:0] {
        OP_PASS_A = 3'd0,
        OP_PASS_B = 3'd1,
        OP_ADD    = 3'd2,
        OP_SUB    = 3'd3,
        OP_AND    = 3'd4,
        OP_OR     = 3'd5,
        OP_XOR    = 3'd6,
        OP_NOT_A  = 3'd7
    } alu_op_e;

    typedef struct packed {
        alu_op_e op;
        addr_u   read_a;
        addr_u   read_b;
        addr_u   write_a;
        addr_u   write_b;
    } instr_t;

    // ------------------------------------------------------------------
    // Stage interfaces

    // Registered output of I/O predication, travels alongside the memory read
    typedef struct packed {
        logic    live;
        logic    ready;
        logic    rd_io_a;
        logic    rd_io_b;
        word_t   io_word_a;
        word_t   io_word_b;
        logic    wr_io_a;
        logic    wr_io_b;
        addr_u   write_a;
        addr_u   write_b;
        alu_op_e op;
    } pred_t;

    typedef struct packed {
        word_t a;
        word_t b;
    } mem_rd_t;

    // Writeback into the data memories, one result to both sides
    typedef struct packed {
        logic  en_a;
        logic  en_b;
        addr_u addr_a;
        addr_u addr_b;
        word_t data;
    } mem_wr_t;

endpackage

// ==== include/dp_macros.svh ====
// Datapath width, I/O port count and I/O address region macros

`ifndef DP_MACROS_SVH
`define DP_MACROS_SVH

// ----------------------------------------------------------------------
// Data and address widths

// One data word, same width for both memories and all I/O ports
`define DP_WORD_WIDTH 16

// Operand address, same width for reads and writes
`define DP_ADDR_WIDTH 8

// ALU operation code
`define DP_OP_WIDTH 3

// ----------------------------------------------------------------------
// I/O ports

// Ports per side (A and B each have their own set)
`define DP_IO_PORT_COUNT 4
`define DP_IO_PORT_BITS 2

// Top address bits that select the I/O ports instead of memory.
// The low DP_IO_PORT_BITS of the address then pick the port.
`define DP_IO_REGION 6'b11_1111

`endif
